/* bench/har_bnn_model.svh */
`ifndef HAR_BNN_MODEL_SVH
`define HAR_BNN_MODEL_SVH

// reference model, recomputes the network from the weight table in plain integers

function automatic hidden_bits_t hidden_from_frame(feature_frame_t fr);
    hidden_bits_t bits;
    int sum;

    for (int n = 0; n < HIDDEN_CNT; n++) begin
        sum = 0;
        for (int f = 0; f < FEAT_CNT; f++) begin
            if (W_HID_POS[n][f]) begin
                sum += int'(fr.feat[f]);
            end
            if (W_HID_NEG[n][f]) begin
                sum -= int'(fr.feat[f]);
            end
        end
        // zero sum gives a set bit
        bits[n] = (sum >= 0);
    end
    return bits;
endfunction

function automatic class_scores_t scores_from_hidden(hidden_bits_t hb);
    class_scores_t s;
    int agree;

    for (int c = 0; c < CLASS_CNT; c++) begin
        agree = 0;
        for (int h = 0; h < HIDDEN_CNT; h++) begin
            if (hb[h] == W_OUT[c][h]) begin
                agree++;
            end
        end
        s.score[c] = score_t'(agree);
    end
    return s;
endfunction

function automatic int top_score(class_scores_t s);
    int best;

    best = 0;
    for (int c = 0; c < CLASS_CNT; c++) begin
        if (int'(s.score[c]) > best) begin
            best = int'(s.score[c]);
        end
    end
    return best;
endfunction

function automatic int top_score_count(class_scores_t s);
    int top;
    int count;

    top = top_score(s);
    count = 0;
    for (int c = 0; c < CLASS_CNT; c++) begin
        if (int'(s.score[c]) == top) begin
            count++;
        end
    end
    return count;
endfunction

// first class, counting up, that reaches the top score
function automatic logic [CLASS_BITS-1:0] first_max_class(class_scores_t s);
    int top;
    int pick;
    bit found;

    top = top_score(s);
    pick = 0;
    found = 0;
    for (int c = 0; c < CLASS_CNT; c++) begin
        if (!found && int'(s.score[c]) == top) begin
            pick = c;
            found = 1;
        end
    end
    return CLASS_BITS'(pick);
endfunction

// scans downward, so the last hit is the lowest tied index
function automatic logic [CLASS_BITS-1:0] lowest_tied_class(class_scores_t s);
    int top;
    int pick;

    top = top_score(s);
    pick = CLASS_CNT - 1;
    for (int c = CLASS_CNT - 1; c >= 0; c--) begin
        if (int'(s.score[c]) == top) begin
            pick = c;
        end
    end
    return CLASS_BITS'(pick);
endfunction

`endif

/* bench/tb_har_bnn.sv */
`timescale 1ns/1ps

module tb_har_bnn;

    import har_bnn_pkg::*;

    `include "har_bnn_model.svh"

    localparam int SEED            = 32'hcdb6b122;
    localparam int RANDOM_FRAMES   = 300;
    localparam int BURST_CNT       = 8;
    localparam int MAX_BURST       = 20;
    localparam int DRAIN_TIMEOUT   = 50;
    localparam int WATCHDOG_CYCLES = 20000;

    // what the model says one frame must produce
    typedef struct packed {
        logic [CLASS_BITS-1:0] pred;
        logic                  tie;
        logic [CLASS_BITS-1:0] tie_low;
    } expect_t;

    logic                  clk;
    logic                  reset;
    logic                  frame_valid;
    feature_frame_t        frame;
    logic                  prediction_valid;
    logic [CLASS_BITS-1:0] prediction;

    expect_t expect_q[$];
    expect_t cur_exp;

    int errors;
    int frame_count;
    int pred_count;
    int tie_seen;

    har_bnn_top dut (
        .clk              (clk),
        .reset            (reset),
        .frame_valid      (frame_valid),
        .frame            (frame),
        .prediction_valid (prediction_valid),
        .prediction       (prediction)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // nothing comes out while reset is held
    a_reset_quiet: assert property (
        @(posedge clk) (reset && $past(reset)) |-> !prediction_valid
    ) else begin
        errors++;
        $display("[ERROR] %0t ns prediction_valid expected 0 actual %0b",
                 $time, $sampled(prediction_valid));
    end

    // each strobe reappears exactly three edges later, and never without one
    a_valid_lag: assert property (
        @(posedge clk) disable iff (reset)
        prediction_valid == $past(frame_valid, 3)
    ) else begin
        errors++;
        $display("[ERROR] %0t ns prediction_valid expected %0b actual %0b",
                 $time, $past(frame_valid, 3), $sampled(prediction_valid));
    end

    a_pred_match: assert property (
        @(posedge clk) disable iff (reset)
        prediction_valid |-> (prediction == cur_exp.pred)
    ) else begin
        errors++;
        $display("[ERROR] %0t ns prediction expected %0d actual %0d",
                 $time, cur_exp.pred, $sampled(prediction));
    end

    a_tie_lowest: assert property (
        @(posedge clk) disable iff (reset)
        (prediction_valid && cur_exp.tie) |-> (prediction == cur_exp.tie_low)
    ) else begin
        errors++;
        $display("[ERROR] %0t ns prediction expected %0d actual %0d (tied scores)",
                 $time, cur_exp.tie_low, $sampled(prediction));
    end

    // outputs are stable at the falling edge, the expected entry is lined up there
    always @(negedge clk) begin
        if (!reset && prediction_valid) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("a prediction came out at %0t ns with no frame left to match", $time);
            end else begin
                cur_exp = expect_q.pop_front();
                if (cur_exp.tie) begin
                    tie_seen++;
                end
            end
            pred_count++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("simulation ran past its cycle limit without finishing");
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic send_frame(input feature_frame_t f);
        hidden_bits_t  hb;
        class_scores_t sc;
        expect_t       e;

        hb = hidden_from_frame(f);
        sc = scores_from_hidden(hb);
        e.pred = first_max_class(sc);
        e.tie = (top_score_count(sc) > 1);
        e.tie_low = lowest_tied_class(sc);
        @(posedge clk);
        frame_valid <= 1'b1;
        frame <= f;
        expect_q.push_back(e);
        frame_count++;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            frame_valid <= 1'b0;
        end
    endtask

    function automatic feature_frame_t random_frame();
        feature_frame_t f;

        for (int i = 0; i < FEAT_CNT; i++) begin
            f.feat[i] = feature_t'($urandom_range(0, FEAT_MAX));
        end
        return f;
    endfunction

    task automatic wait_drain();
        int cycles;

        cycles = 0;
        while (pred_count < frame_count && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (pred_count < frame_count) begin
            errors++;
            $display("timed out waiting for %0d outstanding predictions",
                     frame_count - pred_count);
        end
    endtask

    initial begin
        feature_frame_t f;
        int burst_len;

        reset = 1'b1;
        frame_valid = 1'b0;
        frame = '0;
        cur_exp = '0;
        errors = 0;
        frame_count = 0;
        pred_count = 0;
        tie_seen = 0;
        void'($urandom(SEED));

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        idle_cycles(6);

        // corner frames, all zero then all full scale
        send_frame('0);
        f = '0;
        for (int i = 0; i < FEAT_CNT; i++) begin
            f.feat[i] = feature_t'(FEAT_MAX);
        end
        send_frame(f);
        idle_cycles(1);

        // one feature at full scale at a time
        for (int k = 0; k < FEAT_CNT; k++) begin
            f = '0;
            f.feat[k] = feature_t'(FEAT_MAX);
            send_frame(f);
        end
        idle_cycles(1);
        wait_drain();

        for (int i = 0; i < RANDOM_FRAMES; i++) begin
            send_frame(random_frame());
            idle_cycles($urandom_range(0, 3));
        end
        idle_cycles(1);
        wait_drain();

        // back to back bursts, the first one at full length
        for (int b = 0; b < BURST_CNT; b++) begin
            burst_len = (b == 0) ? MAX_BURST : $urandom_range(1, MAX_BURST);
            for (int i = 0; i < burst_len; i++) begin
                send_frame(random_frame());
            end
            idle_cycles($urandom_range(1, 4));
        end
        wait_drain();
        idle_cycles(5);

        if (pred_count != frame_count) begin
            errors++;
            $display("sent %0d frames but saw %0d predictions", frame_count, pred_count);
        end
        if (expect_q.size() != 0) begin
            errors++;
            $display("%0d expected results were never matched", expect_q.size());
        end
        if (tie_seen == 0) begin
            errors++;
            $display("no frame with tied top scores reached the tie check");
        end

        $display("frames %0d, predictions %0d, ties %0d, errors %0d",
                 frame_count, pred_count, tie_seen, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+logic
+incdir+bench
logic/har_bnn_pkg.sv
logic/bnn_hidden_layer.sv
logic/bnn_output_layer.sv
logic/argmax.sv
logic/har_bnn_top.sv
bench/tb_har_bnn.sv

/* logic/argmax.sv */
`timescale 1ns/1ps

module argmax #(
    parameter int SIZE = 6,
    parameter int BITS = 6
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     score_valid,
    input  logic [SIZE*BITS-1:0]     scores,
    output logic                     out_valid,
    output logic [$clog2(SIZE)-1:0]  index
);

    localparam int IDX_BITS = $clog2(SIZE);

    logic [BITS-1:0]     best_score;
    logic [IDX_BITS-1:0] best_index;

    // linear scan, only a strictly larger score wins so ties stay at the lower index
    always_comb begin
        best_score = scores[BITS-1:0];
        best_index = '0;
        for (int i = 1; i < SIZE; i++) begin
            if (scores[i*BITS +: BITS] > best_score) begin
                best_score = scores[i*BITS +: BITS];
                best_index = IDX_BITS'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= score_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (score_valid) begin
            index <= best_index;
        end
    end

    // matters when SIZE is not a power of two
    a_index_range: assert property (
        @(posedge clk) disable iff (reset)
        out_valid |-> (index < SIZE)
    ) else $error("argmax index %0d not below %0d", index, SIZE);

endmodule

/* logic/bnn_hidden_layer.sv */
`timescale 1ns/1ps

module bnn_hidden_layer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         frame_valid,
    input  har_bnn_pkg::feature_frame_t  frame,
    output logic                         hid_valid,
    output har_bnn_pkg::hidden_bits_t    hidden
);

    import har_bnn_pkg::*;

    hidden_bits_t sign_bits;

    // every neuron sums its selected features with sign, only the sign is kept
    always_comb begin
        hsum_t acc;
        hsum_t feat_ext;

        for (int n = 0; n < HIDDEN_CNT; n++) begin
            acc = '0;
            for (int f = 0; f < FEAT_CNT; f++) begin
                // features are unsigned, extend with a zero msb
                feat_ext = hsum_t'({1'b0, frame.feat[f]});
                if (W_HID_POS[n][f]) begin
                    acc = acc + feat_ext;
                end else if (W_HID_NEG[n][f]) begin
                    acc = acc - feat_ext;
                end
            end
            // a zero sum counts as positive
            sign_bits[n] = ~acc[HSUM_BITS-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hid_valid <= 1'b0;
        end else begin
            hid_valid <= frame_valid;
        end
    end

    // payload only moves with a frame, otherwise it holds
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            hidden <= sign_bits;
        end
    end

    // the upstream source must present a fully defined frame with the strobe
    a_frame_known: assert property (
        @(posedge clk) disable iff (reset)
        frame_valid |-> !$isunknown(frame)
    ) else $error("frame has unknown bits while frame_valid is high");

endmodule

/* logic/bnn_output_layer.sv */
`timescale 1ns/1ps

module bnn_output_layer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        hid_valid,
    input  har_bnn_pkg::hidden_bits_t   hidden,
    output logic                        score_valid,
    output har_bnn_pkg::class_scores_t  scores
);

    import har_bnn_pkg::*;

    class_scores_t next_scores;

    // xnor against the class weight, then popcount
    always_comb begin
        hidden_bits_t agree;

        next_scores = '0;
        for (int c = 0; c < CLASS_CNT; c++) begin
            agree = ~(hidden ^ W_OUT[c]);
            for (int h = 0; h < HIDDEN_CNT; h++) begin
                next_scores.score[c] = next_scores.score[c] + score_t'(agree[h]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            score_valid <= 1'b0;
        end else begin
            score_valid <= hid_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (hid_valid) begin
            scores <= next_scores;
        end
    end

    // a registered count can never exceed the number of hidden bits
    for (genvar c = 0; c < CLASS_CNT; c++) begin : g_score_chk
        a_score_range: assert property (
            @(posedge clk) disable iff (reset)
            score_valid |-> (scores.score[c] <= score_t'(HIDDEN_CNT))
        ) else $error("class %0d score %0d above %0d", c, scores.score[c], HIDDEN_CNT);
    end

endmodule

/* logic/har_bnn_pkg.sv */
package har_bnn_pkg;

    // network dimensions, fixed by the trained weight set
    localparam int FEAT_CNT   = 12;
    localparam int FEAT_BITS  = 4;
    localparam int HIDDEN_CNT = 40;
    localparam int CLASS_CNT  = 6;

    // largest unsigned feature value
    localparam int FEAT_MAX = (1 << FEAT_BITS) - 1;

    localparam int CLASS_BITS = $clog2(CLASS_CNT);

    // a score counts agreeing hidden bits, so it runs from 0 to HIDDEN_CNT
    localparam int SCORE_BITS = $clog2(HIDDEN_CNT + 1);

    // neuron sum spans -FEAT_CNT*FEAT_MAX .. +FEAT_CNT*FEAT_MAX plus a sign bit
    localparam int HSUM_BITS = $clog2(FEAT_CNT * FEAT_MAX + 1) + 1;

    // scalar building blocks
    typedef logic [FEAT_BITS-1:0] feature_t;

    typedef logic signed [HSUM_BITS-1:0] hsum_t;

    typedef logic [SCORE_BITS-1:0] score_t;

    // one bit per input feature, used for the ternary weight masks
    typedef logic [FEAT_CNT-1:0] feat_mask_t;

    // one sensor frame, feature 0 sits in the lowest bits
    typedef struct packed {
        feature_t [FEAT_CNT-1:0] feat;
    } feature_frame_t;

    // bit i set when neuron i has a non-negative sum
    typedef logic [HIDDEN_CNT-1:0] hidden_bits_t;

    // per class agreement counts, class 0 in the lowest bits
    typedef struct packed {
        score_t [CLASS_CNT-1:0] score;
    } class_scores_t;

    // hidden layer weights are ternary
    //   pos bit set  -> feature is added
    //   neg bit set  -> feature is subtracted
    //   neither      -> feature is ignored
    // output layer weights are binary, a hidden bit agrees when it matches
    `include "har_bnn_weights.svh"

endpackage

/* logic/har_bnn_top.sv */
`timescale 1ns/1ps

module har_bnn_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                frame_valid,
    input  har_bnn_pkg::feature_frame_t         frame,
    output logic                                prediction_valid,
    output logic [har_bnn_pkg::CLASS_BITS-1:0]  prediction
);

    import har_bnn_pkg::*;

    // stage 1 to stage 2
    logic          hid_valid;
    hidden_bits_t  hidden;

    // stage 2 to stage 3
    logic          score_valid;
    class_scores_t scores;

    bnn_hidden_layer u_hidden (
        .clk         (clk),
        .reset       (reset),
        .frame_valid (frame_valid),
        .frame       (frame),
        .hid_valid   (hid_valid),
        .hidden      (hidden)
    );

    bnn_output_layer u_output (
        .clk         (clk),
        .reset       (reset),
        .hid_valid   (hid_valid),
        .hidden      (hidden),
        .score_valid (score_valid),
        .scores      (scores)
    );

    // winner select over the class scores
    argmax #(
        .SIZE (CLASS_CNT),
        .BITS (SCORE_BITS)
    ) u_argmax (
        .clk         (clk),
        .reset       (reset),
        .score_valid (score_valid),
        .scores      (scores),
        .out_valid   (prediction_valid),
        .index       (prediction)
    );

endmodule

/* logic/har_bnn_weights.svh */
`ifndef HAR_BNN_WEIGHTS_SVH
`define HAR_BNN_WEIGHTS_SVH

// generated from the trained network, do not edit by hand
// indexed by hidden neuron, bit f of a mask refers to feature f

localparam feat_mask_t W_HID_POS [HIDDEN_CNT] = '{
    12'h5a3, 12'h0c6, 12'h91e, 12'h347, 12'ha0d, 12'h6b1, 12'h1f8, 12'hc24,
    12'h78a, 12'h253, 12'he09, 12'h4d5, 12'h8e2, 12'h13c, 12'hb61, 12'h0f3,
    12'h6a9, 12'hd14, 12'h3c7, 12'ha92, 12'h58e, 12'h2b5, 12'hf02, 12'h94c,
    12'h0a7, 12'hc39, 12'h7d0, 12'h16e, 12'hb4a, 12'h4e3, 12'h83d, 12'h2f1,
    12'he58, 12'h5c6, 12'h9a4, 12'h39b, 12'hd62, 12'h0b9, 12'h6e5, 12'ha1f
};

// disjoint from W_HID_POS for every neuron
localparam feat_mask_t W_HID_NEG [HIDDEN_CNT] = '{
    12'ha58, 12'h739, 12'h6c1, 12'hc98, 12'h5b2, 12'h14e, 12'ha07, 12'h3d3,
    12'h865, 12'hd2c, 12'h1b6, 12'hb28, 12'h70d, 12'he43, 12'h49a, 12'hd0c,
    12'h916, 12'h2e3, 12'h838, 12'h469, 12'ha61, 12'hc4a, 12'h0f9, 12'h6a3,
    12'hf18, 12'h3c2, 12'h82b, 12'hc91, 12'h4a5, 12'hb14, 12'h7c0, 12'h90e,
    12'h1a3, 12'ha31, 12'h64b, 12'hc44, 12'h28d, 12'he46, 12'h912, 12'h5a0
};

// indexed by class, bit h is the weight for hidden neuron h
localparam hidden_bits_t W_OUT [CLASS_CNT] = '{
    40'h9c3a5e71d2,
    40'h63c5a18e2d,
    40'hb5960f3ca7,
    40'h4a69f0c358,
    40'hd20b7e4c96,
    40'h2df481b369
};

`endif

/* run.sh */
#!/bin/sh
# build and run the classifier testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_har_bnn -f filelist.f

if ! ./obj_dir/Vtb_har_bnn > sim.log 2>&1; then
    cat sim.log
    echo "simulator exited with an error"
    exit 1
fi

cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "no pass message found in sim.log"
    exit 1
fi
exit 0
